/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_frontend
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing -Wall -Wno-fatal
SIM_FLAGS  ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/fetch_buffer.sv */
`default_nettype none
`timescale 1ns/1ps

module fetch_buffer #(
  parameter int FB_DEPTH = 8
) (
  input  wire logic                            clock,
  input  wire logic                            rst_n,
  input  wire logic                            redirect_en,
  input  wire logic                            fetch_valid,
  input  wire fetch_pkg::fb_entry_t            fetch_entry,
  input  wire logic                            dispatch_en,
  output logic                                 fetch_en,
  output logic                                 inst_valid,
  output logic      [fetch_pkg::INST_W-1:0]    inst_ir,
  output logic      [mem_bus_pkg::ADDR_W-1:0]  inst_npc
);

  localparam int PTR_W = $clog2(FB_DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(FB_DEPTH);

  fetch_pkg::fb_entry_t entries [FB_DEPTH];

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign fetch_en   = (count != FULL_CNT);
  assign inst_valid = (count != '0);
  assign push       = fetch_valid && fetch_en;
  assign pop        = dispatch_en && inst_valid;

  // Head of queue goes straight out
  assign inst_ir  = entries[head].inst;
  assign inst_npc = entries[head].npc;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (redirect_en) begin
      // Drop everything fetched down the old path
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) tail <= tail + PTR_W'(1);  // Wraps, depth is a power of two
      if (pop) head <= head + PTR_W'(1);
      count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (push) entries[tail] <= fetch_entry;
  end

endmodule

`default_nettype wire

/* design/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  localparam int INST_W = 32;

  // Block is 8 bytes, two instructions per line
  localparam int OFFSET_W = 3;
  localparam int CTAG_W   = 8; // Tag bits above the index

  // One fetch buffer slot
  typedef struct packed {
    logic [INST_W-1:0]              inst;
    logic [mem_bus_pkg::ADDR_W-1:0] npc;  // PC of the following instruction
  } fb_entry_t;

  // Miss handling in the instruction cache controller
  typedef enum logic [1:0] {
    IC_IDLE = 2'h0,
    IC_REQ  = 2'h1,  // Command on the bus until accepted
    IC_WAIT = 2'h2   // Waiting for the tag to come back
  } ictrl_state_e;

endpackage

`default_nettype wire

/* design/fetch_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module fetch_stage (
  input  wire logic                           clock,
  input  wire logic                           rst_n,
  input  wire logic                           redirect_en,
  input  wire logic [mem_bus_pkg::ADDR_W-1:0] redirect_pc,
  input  wire logic [mem_bus_pkg::DATA_W-1:0] fetch_block,
  input  wire logic                           fetch_hit,
  input  wire logic                           fetch_en,
  output logic      [mem_bus_pkg::ADDR_W-1:0] fetch_addr,
  output logic                                fetch_valid,
  output fetch_pkg::fb_entry_t                fetch_entry
);

  logic [mem_bus_pkg::ADDR_W-1:0] pc;
  logic [mem_bus_pkg::ADDR_W-1:0] pc_next;
  logic [fetch_pkg::INST_W-1:0]   inst;

  assign fetch_addr = pc;
  assign pc_next    = pc + mem_bus_pkg::ADDR_W'(4);

  // Word select within the 8-byte block
  assign inst = pc[2] ? fetch_block[2*fetch_pkg::INST_W-1:fetch_pkg::INST_W]
                      : fetch_block[fetch_pkg::INST_W-1:0];

  assign fetch_valid      = fetch_hit && fetch_en;
  assign fetch_entry.inst = inst;
  assign fetch_entry.npc  = pc_next;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (redirect_en) begin
      pc <= redirect_pc;  // Redirect beats a push
    end else if (fetch_valid) begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

/* design/frontend.sv */
`default_nettype none
`timescale 1ns/1ps

module frontend #(
  parameter int NUM_LINES = 32,
  parameter int FB_DEPTH  = 8
) (
  input  wire logic                           clock,
  input  wire logic                           rst_n,
  input  wire logic [mem_bus_pkg::TAG_W-1:0]  mem2proc_response, // Tag for the current command
  input  wire logic [mem_bus_pkg::TAG_W-1:0]  mem2proc_tag,      // Tag of returning data
  input  wire logic [mem_bus_pkg::DATA_W-1:0] mem2proc_data,
  input  wire logic                           dispatch_ready,
  input  wire logic                           redirect_en,
  input  wire logic [mem_bus_pkg::ADDR_W-1:0] redirect_pc,
  output mem_bus_pkg::bus_cmd_e               proc2mem_command,
  output logic      [mem_bus_pkg::ADDR_W-1:0] proc2mem_addr,
  output logic                                inst_valid,
  output logic      [fetch_pkg::INST_W-1:0]   inst_ir,
  output logic      [mem_bus_pkg::ADDR_W-1:0] inst_npc,
  output logic                                dispatch_en
);

  logic [mem_bus_pkg::ADDR_W-1:0] fetch_addr;
  logic [mem_bus_pkg::DATA_W-1:0] fetch_block;
  logic                           fetch_hit;
  logic                           fetch_en;
  logic                           fetch_valid;
  fetch_pkg::fb_entry_t           fetch_entry;

  // Pop whenever downstream can take one and no redirect is under way
  assign dispatch_en = dispatch_ready && inst_valid && !redirect_en;

  icache_if #(.NUM_LINES(NUM_LINES)) cache_bus ();

  icache_mem #(.NUM_LINES(NUM_LINES)) u_icache_mem (
    .clock (clock),
    .rst_n (rst_n),
    .port  (cache_bus.mem)
  );

  icache_ctrl #(.NUM_LINES(NUM_LINES)) u_icache_ctrl (
    .clock             (clock),
    .rst_n             (rst_n),
    .fetch_addr        (fetch_addr),
    .redirect_en       (redirect_en),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .fetch_block       (fetch_block),
    .fetch_hit         (fetch_hit),
    .cache             (cache_bus.ctrl)
  );

  fetch_stage u_fetch_stage (
    .clock       (clock),
    .rst_n       (rst_n),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .fetch_block (fetch_block),
    .fetch_hit   (fetch_hit),
    .fetch_en    (fetch_en),
    .fetch_addr  (fetch_addr),
    .fetch_valid (fetch_valid),
    .fetch_entry (fetch_entry)
  );

  fetch_buffer #(.FB_DEPTH(FB_DEPTH)) u_fetch_buffer (
    .clock       (clock),
    .rst_n       (rst_n),
    .redirect_en (redirect_en),
    .fetch_valid (fetch_valid),
    .fetch_entry (fetch_entry),
    .dispatch_en (dispatch_en),
    .fetch_en    (fetch_en),
    .inst_valid  (inst_valid),
    .inst_ir     (inst_ir),
    .inst_npc    (inst_npc)
  );

endmodule

`default_nettype wire

/* design/icache_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module icache_ctrl #(
  parameter int NUM_LINES = 32
) (
  input  wire logic                           clock,
  input  wire logic                           rst_n,
  input  wire logic [mem_bus_pkg::ADDR_W-1:0] fetch_addr,
  input  wire logic                           redirect_en,
  input  wire logic [mem_bus_pkg::TAG_W-1:0]  mem2proc_response,
  input  wire logic [mem_bus_pkg::TAG_W-1:0]  mem2proc_tag,
  input  wire logic [mem_bus_pkg::DATA_W-1:0] mem2proc_data,
  output mem_bus_pkg::bus_cmd_e               proc2mem_command,
  output logic      [mem_bus_pkg::ADDR_W-1:0] proc2mem_addr,
  output logic      [mem_bus_pkg::DATA_W-1:0] fetch_block,
  output logic                                fetch_hit,
  icache_if.ctrl                              cache
);

  localparam int IDX_W = $clog2(NUM_LINES);
  localparam int TAG_LSB = fetch_pkg::OFFSET_W + IDX_W;

  fetch_pkg::ictrl_state_e state, state_nxt;

  logic [mem_bus_pkg::ADDR_W-1:0] req_addr;  // Block address of the miss
  logic [mem_bus_pkg::TAG_W-1:0]  pend_tag;
  logic                           pend;      // Fill still owed by memory
  logic                           start_miss;
  logic                           accepted;
  logic                           fill_done;

  // Lookup for the current fetch address
  assign cache.rd_idx = fetch_addr[fetch_pkg::OFFSET_W +: IDX_W];
  assign cache.rd_tag = fetch_addr[TAG_LSB +: fetch_pkg::CTAG_W];
  assign fetch_block  = cache.rd_data;
  assign fetch_hit    = cache.rd_valid;

  // Only one miss on the bus at a time, even an abandoned one
  assign start_miss = (state == fetch_pkg::IC_IDLE) && !cache.rd_valid && !pend && !redirect_en;
  assign accepted   = (state == fetch_pkg::IC_REQ) && (mem2proc_response != '0);
  assign fill_done  = pend && (mem2proc_tag == pend_tag);

  assign proc2mem_command = (state == fetch_pkg::IC_REQ) ? mem_bus_pkg::BUS_LOAD
                                                         : mem_bus_pkg::BUS_NONE;
  assign proc2mem_addr    = (state == fetch_pkg::IC_REQ) ? req_addr : '0;

  // Fill goes in even after a redirect
  assign cache.wr_en   = fill_done;
  assign cache.wr_idx  = req_addr[fetch_pkg::OFFSET_W +: IDX_W];
  assign cache.wr_tag  = req_addr[TAG_LSB +: fetch_pkg::CTAG_W];
  assign cache.wr_data = mem2proc_data;

  always_comb begin
    state_nxt = state;
    case (state)
      fetch_pkg::IC_IDLE: begin
        if (start_miss) state_nxt = fetch_pkg::IC_REQ;
      end
      fetch_pkg::IC_REQ: begin
        if (redirect_en) state_nxt = fetch_pkg::IC_IDLE;
        else if (accepted) state_nxt = fetch_pkg::IC_WAIT;
      end
      fetch_pkg::IC_WAIT: begin
        if (redirect_en || fill_done) state_nxt = fetch_pkg::IC_IDLE;
      end
      default: state_nxt = fetch_pkg::IC_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state <= fetch_pkg::IC_IDLE;
      pend  <= 1'b0;
    end else begin
      state <= state_nxt;
      if (accepted) pend <= 1'b1;  // Held across a redirect
      else if (fill_done) pend <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (start_miss) begin
      req_addr <= {fetch_addr[mem_bus_pkg::ADDR_W-1:fetch_pkg::OFFSET_W],
                   fetch_pkg::OFFSET_W'(0)};
    end
    if (accepted) pend_tag <= mem2proc_response;
  end

endmodule

`default_nettype wire

/* design/icache_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface icache_if #(
  parameter int NUM_LINES = 32
);

  localparam int IDX_W = $clog2(NUM_LINES);

  logic [IDX_W-1:0]               rd_idx;
  logic [fetch_pkg::CTAG_W-1:0]   rd_tag;
  logic [mem_bus_pkg::DATA_W-1:0] rd_data;
  logic                           rd_valid;  // Line valid and tag matches
  logic                           wr_en;
  logic [IDX_W-1:0]               wr_idx;
  logic [fetch_pkg::CTAG_W-1:0]   wr_tag;
  logic [mem_bus_pkg::DATA_W-1:0] wr_data;

  modport ctrl (
    output rd_idx, rd_tag, wr_en, wr_idx, wr_tag, wr_data,
    input  rd_data, rd_valid
  );

  modport mem (
    input  rd_idx, rd_tag, wr_en, wr_idx, wr_tag, wr_data,
    output rd_data, rd_valid
  );

endinterface

`default_nettype wire

/* design/icache_mem.sv */
`default_nettype none
`timescale 1ns/1ps

module icache_mem #(
  parameter int NUM_LINES = 32
) (
  input wire logic clock,
  input wire logic rst_n,
  icache_if.mem    port
);

  logic [NUM_LINES-1:0]           valid;
  logic [fetch_pkg::CTAG_W-1:0]   tags [NUM_LINES];
  logic [mem_bus_pkg::DATA_W-1:0] data [NUM_LINES];

  // Combinational lookup
  assign port.rd_data  = data[port.rd_idx];
  assign port.rd_valid = valid[port.rd_idx] && (tags[port.rd_idx] == port.rd_tag);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
    end else if (port.wr_en) begin
      valid[port.wr_idx] <= 1'b1;
    end
  end

  // Tag and block storage
  always_ff @(posedge clock) begin
    if (port.wr_en) begin
      tags[port.wr_idx] <= port.wr_tag;
      data[port.wr_idx] <= port.wr_data;
    end
  end

endmodule

`default_nettype wire

/* design/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

  // Processor to memory command
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  localparam int ADDR_W = 64; // Byte address
  localparam int DATA_W = 64; // One block per transfer

  // Transaction tag, zero when the memory did not take the command
  localparam int TAG_W = 4;

endpackage

`default_nettype wire

/* test/frontend_checker.sv */
`default_nettype none
`timescale 1ns/1ps

module frontend_checker (
  input wire logic        clock,
  input wire logic        rst_n,
  input wire logic        dispatch_ready,
  input wire logic        dispatch_en,
  input wire logic        inst_valid,
  input wire logic [31:0] inst_ir,
  input wire logic [63:0] inst_npc,
  input wire logic        redirect_en,
  input wire logic [63:0] redirect_pc,
  input wire logic [3:0]  mem2proc_tag,
  input wire logic [31:0] load_count
);

  string       test_name = "reset";
  int          error_count = 0;
  int          check_count = 0;
  int          test_errors = 0;
  int          check_base = 0;
  int          load_base = 0;
  logic [63:0] exp_pc;     // PC of the next instruction to dispatch
  logic        seen_fill;

  // Memory contents by rule
  function automatic logic [31:0] word_at(input logic [63:0] addr);
    return addr[31:0] ^ 32'h5a5a0000;
  endfunction

  task automatic flag_error();
    error_count++;
    test_errors++;
  endtask

  always @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc    = '0;
      seen_fill = 1'b0;
    end else begin
      if (mem2proc_tag != '0) seen_fill = 1'b1;
      if (inst_valid && !seen_fill) begin
        $display("Instruction visible before the first cache fill in %s", test_name);
        flag_error();
      end
      if (dispatch_en && (!dispatch_ready || !inst_valid || redirect_en)) begin
        $display("Dispatch without ready, without an instruction or during a redirect in %s",
                 test_name);
        flag_error();
      end
      if (redirect_en) begin
        exp_pc = redirect_pc;
      end else if (dispatch_en) begin
        check_count++;
        if (inst_npc != exp_pc + 64'd4) begin
          $display("[ERROR] %s: npc expected %h actual %h", test_name, exp_pc + 64'd4, inst_npc);
          flag_error();
        end
        if (inst_ir != word_at(exp_pc)) begin
          $display("[ERROR] %s: ir at %h expected %h actual %h",
                   test_name, exp_pc, word_at(exp_pc), inst_ir);
          flag_error();
        end
        exp_pc = exp_pc + 64'd4;
      end
    end
  end

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    check_base  = check_count;
    load_base   = int'(load_count);
  endtask

  task automatic end_test(input int exp_loads);
    int loads;
    loads = int'(load_count) - load_base;
    if (loads != exp_loads) begin
      $display("[ERROR] %s: loads expected %0d actual %0d", test_name, exp_loads, loads);
      flag_error();
    end
    $display("Test %s done: %0d dispatched, %0d loads, %0d errors",
             test_name, check_count - check_base, loads, test_errors);
  endtask

endmodule

`default_nettype wire

/* test/frontend_sva.sv */
`default_nettype none
`timescale 1ns/1ps

module frontend_sva (
  input wire logic                  clock,
  input wire logic                  rst_n,
  input wire mem_bus_pkg::bus_cmd_e proc2mem_command,
  input wire logic [63:0]           proc2mem_addr,
  input wire logic                  redirect_en,
  input wire logic                  inst_valid
);

  int fail_count = 0;

  // Bus stays quiet while reset is held
  reset_quiet: assert property (@(posedge clock)
      !rst_n |-> proc2mem_command == mem_bus_pkg::BUS_NONE)
    else begin
      fail_count++;
      $error("Memory command issued during reset");
    end

  flush_empties: assert property (@(posedge clock) disable iff (!rst_n)
      redirect_en |=> !inst_valid)
    else begin
      fail_count++;
      $error("Fetch buffer not empty after redirect");
    end

  load_aligned: assert property (@(posedge clock) disable iff (!rst_n)
      proc2mem_command == mem_bus_pkg::BUS_LOAD |-> proc2mem_addr[2:0] == 3'b000)
    else begin
      fail_count++;
      $error("Load address not block aligned");
    end

endmodule

bind frontend frontend_sva u_frontend_sva (.*);

`default_nettype wire

/* test/tb_clk_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD = 50  // 100 ns clock
) (
  output logic clock
);

  initial clock = 1'b0;
  always #(HALF_PERIOD) clock = ~clock;

endmodule

`default_nettype wire

/* test/tb_frontend.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_frontend;

  typedef struct {
    string       name;
    bit          redirect;
    logic [63:0] target;
    int          count;      // Instructions to dispatch
    bit          random_bp;  // dispatch_ready toggled at random
    int          loads;      // New BUS_LOAD commands
  } test_row_t;

  localparam int NUM_ROWS = 6;
  localparam int TIMEOUT  = 2000;

  logic                  clock;
  logic                  rst_n;
  logic [3:0]            mem2proc_response;
  logic [3:0]            mem2proc_tag;
  logic [63:0]           mem2proc_data;
  logic                  dispatch_ready;
  logic                  redirect_en;
  logic [63:0]           redirect_pc;
  mem_bus_pkg::bus_cmd_e proc2mem_command;
  logic [63:0]           proc2mem_addr;
  logic                  inst_valid;
  logic [31:0]           inst_ir;
  logic [63:0]           inst_npc;
  logic                  dispatch_en;

  test_row_t   rows [NUM_ROWS];
  int          seed = 32'he9fd8065;
  logic        mem_busy;
  logic [3:0]  next_tag;
  logic [3:0]  busy_tag;
  logic [63:0] busy_addr;
  int          busy_delay;
  logic [31:0] load_count;

  tb_clk_gen u_clk_gen (.clock(clock));

  frontend #(.NUM_LINES(32), .FB_DEPTH(8)) u_frontend (.*);

  frontend_checker u_checker (.*);

  // Lower address word sits in the low half of the block
  function automatic logic [63:0] mem_block(input logic [63:0] addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    return {(base + 32'd4) ^ 32'h5a5a0000, base ^ 32'h5a5a0000};
  endfunction

  // Memory model with one block in flight and random retries
  always @(posedge clock) begin
    #1;
    mem2proc_response = '0;
    mem2proc_tag      = '0;
    if (mem_busy) begin
      busy_delay--;
      if (busy_delay == 0) begin
        mem2proc_tag  = busy_tag;
        mem2proc_data = mem_block(busy_addr);
        mem_busy      = 1'b0;
      end
    end
    if (proc2mem_command == mem_bus_pkg::BUS_LOAD && !mem_busy && ($random(seed) & 3) != 0) begin
      mem2proc_response = next_tag;
      busy_tag   = next_tag;
      busy_addr  = proc2mem_addr;
      busy_delay = 1 + ($random(seed) & 3);
      mem_busy   = 1'b1;
      load_count++;
      next_tag   = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;  // Never zero
    end
  end

  task automatic apply_redirect(input logic [63:0] target);
    redirect_en = 1'b1;
    redirect_pc = target;
    @(posedge clock);
    #1;
    redirect_en = 1'b0;
  endtask

  task automatic dispatch_count(input int n, input bit random_bp, output bit ok);
    int done;
    int cycles;
    done   = 0;
    cycles = 0;
    ok     = 1'b1;
    dispatch_ready = random_bp ? 1'($random(seed) & 1) : 1'b1;
    while (done < n) begin
      if (cycles == TIMEOUT) begin
        $display("Timeout in %s: only %0d of %0d dispatched", u_checker.test_name, done, n);
        ok = 1'b0;
        break;
      end
      @(posedge clock);
      if (dispatch_en) done++;
      cycles++;
      #1;
      if (done >= n) dispatch_ready = 1'b0;
      else dispatch_ready = random_bp ? 1'($random(seed) & 1) : 1'b1;
    end
    dispatch_ready = 1'b0;
  endtask

  // Settled once the buffer is full with the PC hitting and no fill owed
  task automatic wait_idle(output bit ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < TIMEOUT && !ok; cycles++) begin
      @(posedge clock);
      ok = !u_frontend.fetch_en && u_frontend.fetch_hit && !mem_busy;
      #1;
    end
    if (!ok) $display("Timeout in %s: fetch did not settle", u_checker.test_name);
  endtask

  initial begin
    int r;
    int rows_run;
    bit ok;
    rst_n             = 1'b0;
    mem2proc_response = '0;
    mem2proc_tag      = '0;
    mem2proc_data     = '0;
    dispatch_ready    = 1'b0;
    redirect_en       = 1'b0;
    redirect_pc       = '0;
    mem_busy          = 1'b0;
    next_tag          = 4'h1;
    load_count        = '0;
    rows[0] = '{"reset_seq",       1'b0, 64'h0,    16, 1'b0, 13};
    rows[1] = '{"seq_backpressure", 1'b0, 64'h0,   24, 1'b1, 12};
    rows[2] = '{"redirect_new",    1'b1, 64'h400,  12, 1'b0, 11};
    rows[3] = '{"redirect_hit",    1'b1, 64'h80,    8, 1'b1, 0};
    rows[4] = '{"redirect_odd",    1'b1, 64'h1004, 10, 1'b1, 10};
    rows[5] = '{"refetch_partial", 1'b1, 64'h40,    8, 1'b0, 3};  // Lines 8 to 10 evicted
    repeat (10) @(posedge clock);
    #1;
    rst_n    = 1'b1;
    ok       = 1'b1;
    rows_run = 0;
    for (r = 0; r < NUM_ROWS && ok; r++) begin
      u_checker.start_test(rows[r].name);
      if (rows[r].redirect) apply_redirect(rows[r].target);
      dispatch_count(rows[r].count, rows[r].random_bp, ok);
      if (ok) wait_idle(ok);
      if (ok) u_checker.end_test(rows[r].loads);
      rows_run++;
    end
    $display("Summary: %0d tests, %0d dispatches checked, %0d errors, %0d assertion failures",
             rows_run, u_checker.check_count, u_checker.error_count,
             u_frontend.u_frontend_sva.fail_count);
    if (ok && u_checker.error_count == 0 && u_frontend.u_frontend_sva.fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
design/mem_bus_pkg.sv
design/fetch_pkg.sv
design/icache_if.sv
design/icache_mem.sv
design/icache_ctrl.sv
design/fetch_stage.sv
design/fetch_buffer.sv
design/frontend.sv
test/tb_clk_gen.sv
test/frontend_checker.sv
test/frontend_sva.sv
test/tb_frontend.sv
